// ==== hw/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

	// CPU word address width.
	localparam int ADDR_W = 16;

	// Data word width, one word per cache line.
	localparam int DATA_W = 32;

	// Set index bits; the tag takes the rest of the address.
	localparam int INDEX_W = 4;
	localparam int TAG_W = ADDR_W - INDEX_W;

	// Sets per way.
	localparam int NUM_SETS = 1 << INDEX_W;

	// Upper bound on associativity, sizes the per-way fields of the bus structs.
	localparam int MAX_WAYS = 4;

endpackage

// ==== hw/cache_bus_pkg.sv ====
package cache_bus_pkg;

	import cache_cfg_pkg::*;

	// CPU request as latched by the controller.
	typedef struct packed {
		logic we;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} cpu_req_t;

	// One way's entry at the current lookup index.
	typedef struct packed {
		logic valid;
		logic dirty;
		logic hit;
		logic [TAG_W-1:0] tag;
		logic [DATA_W-1:0] data;
	} way_status_t;

	// Entry write, broadcast to all ways and qualified by a per-way select.
	typedef struct packed {
		logic [INDEX_W-1:0] index;
		logic [TAG_W-1:0] tag;
		logic [DATA_W-1:0] data;
		logic valid;
		logic dirty;
	} way_wr_t;

	// Hit and victim verdict for the current request.
	typedef struct packed {
		logic hit;
		logic [MAX_WAYS-1:0] hit_way;
		logic [MAX_WAYS-1:0] victim_way;
		logic victim_valid;
		logic victim_dirty;
		logic [TAG_W-1:0] victim_tag;
		logic [DATA_W-1:0] victim_data;
		logic [DATA_W-1:0] rdata;
	} lookup_res_t;

endpackage

// ==== hw/cache_way.sv ====
`timescale 1ns/10ps

module cache_way
	import cache_cfg_pkg::*;
	import cache_bus_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic [INDEX_W-1:0] lookup_index,
	input logic [TAG_W-1:0] lookup_tag,
	input way_wr_t wr,
	input logic sel,
	output way_status_t status
);

	// Valid and dirty flags per set.
	logic [NUM_SETS-1:0] valid_q;
	logic [NUM_SETS-1:0] dirty_q;

	// Tag and data storage.
	logic [TAG_W-1:0] tag_mem [NUM_SETS];
	logic [DATA_W-1:0] data_mem [NUM_SETS];

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			valid_q <= '0;
			dirty_q <= '0;
		end
		else if (sel)
		begin
			valid_q[wr.index] <= wr.valid;
			dirty_q[wr.index] <= wr.dirty;
		end
	end

	always_ff @(posedge clk)
	begin
		if (sel)
		begin
			tag_mem[wr.index] <= wr.tag;
			data_mem[wr.index] <= wr.data;
		end
	end

	// Entry at the lookup index, with the tag compare.
	always_comb
	begin
		status.valid = valid_q[lookup_index];
		status.dirty = dirty_q[lookup_index];
		status.tag = tag_mem[lookup_index];
		status.data = data_mem[lookup_index];
		status.hit = status.valid && (status.tag == lookup_tag);
	end

endmodule

// ==== hw/way_select.sv ====
`timescale 1ns/10ps

module way_select
	import cache_cfg_pkg::*;
	import cache_bus_pkg::*;
#(
	parameter int NUM_WAYS = 2
)
(
	input logic clk,
	input logic rst,
	input way_status_t status [NUM_WAYS],
	input logic [INDEX_W-1:0] lookup_index,
	input logic touch,
	input logic [NUM_WAYS-1:0] touch_way,
	output lookup_res_t res
);

	localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

	// Way to replace next in each set.
	logic [NUM_SETS-1:0][WAY_W-1:0] lru_q;

	logic [WAY_W-1:0] vic_idx;
	logic [WAY_W-1:0] touch_idx;

	// Lowest invalid way wins, else the LRU way.
	always_comb
	begin
		vic_idx = lru_q[lookup_index];
		for (int i = NUM_WAYS - 1; i >= 0; i--)
			if (!status[i].valid)
				vic_idx = WAY_W'(i);
	end

	always_comb
	begin
		res = '0;
		for (int i = 0; i < NUM_WAYS; i++)
		begin
			res.hit_way[i] = status[i].hit;
			if (status[i].hit)
				res.rdata = status[i].data;
		end
		res.hit = |res.hit_way;
		res.victim_way = MAX_WAYS'(1) << vic_idx;
		res.victim_valid = status[vic_idx].valid;
		res.victim_dirty = status[vic_idx].dirty;
		res.victim_tag = status[vic_idx].tag;
		res.victim_data = status[vic_idx].data;
	end

	always_comb
	begin
		touch_idx = '0;
		for (int i = 0; i < NUM_WAYS; i++)
			if (touch_way[i])
				touch_idx = WAY_W'(i);
	end

	// Point past the touched way. This is exact LRU for two ways.
	always_ff @(posedge clk)
	begin
		if (!rst)
			lru_q <= '0;
		else if (touch)
			lru_q[lookup_index] <= (int'(touch_idx) == NUM_WAYS - 1) ? '0 : touch_idx + 1'b1;
	end

	a_single_hit: assert property (@(posedge clk) disable iff (!rst)
		$onehot0(res.hit_way));

endmodule

// ==== hw/cache_controller.sv ====
`timescale 1ns/10ps

module cache_controller
	import cache_cfg_pkg::*;
	import cache_bus_pkg::*;
#(
	parameter int NUM_WAYS = 2
)
(
	input logic clk,
	input logic rst,

	// CPU side.
	input logic cs,
	input logic we,
	input logic [ADDR_W-1:0] addr,
	input logic [DATA_W-1:0] wdata,
	output logic ack,
	output logic [DATA_W-1:0] rdata,

	// Ways and selector.
	input lookup_res_t res,
	output logic [INDEX_W-1:0] lookup_index,
	output logic [TAG_W-1:0] lookup_tag,
	output way_wr_t wr,
	output logic [NUM_WAYS-1:0] wr_sel,
	output logic touch,
	output logic [NUM_WAYS-1:0] touch_way,

	// DRAM side.
	input logic dram_ack,
	input logic [DATA_W-1:0] dram_rdata,
	output logic dram_cs,
	output logic dram_we,
	output logic [ADDR_W-1:0] dram_addr,
	output logic [DATA_W-1:0] dram_wdata
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOOKUP,
		S_WB,
		S_FILL,
		S_UPDATE,
		S_DONE
	} state_t;

	state_t state;
	state_t next_state;

	cpu_req_t req;
	logic [NUM_WAYS-1:0] used_way;
	logic [DATA_W-1:0] line_data;
	logic victim_wb;

	// A miss must first push out a valid dirty victim.
	assign victim_wb = !res.hit && res.victim_valid && res.victim_dirty;

	assign lookup_index = req.addr[INDEX_W-1:0];
	assign lookup_tag = req.addr[ADDR_W-1:INDEX_W];

	always_comb
	begin
		next_state = state;
		case (state)
			S_IDLE:
				if (cs)
					next_state = S_LOOKUP;
			S_LOOKUP:
				if (res.hit)
					next_state = req.we ? S_UPDATE : S_DONE;
				else if (victim_wb)
					next_state = S_WB;
				else
					next_state = S_FILL;
			S_WB:
				if (dram_ack)
					next_state = S_FILL;
			S_FILL:
				if (dram_ack)
					next_state = S_UPDATE;
			S_UPDATE:
				next_state = S_DONE;
			default:
				next_state = S_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state <= S_IDLE;
			dram_cs <= 1'b0;
			dram_we <= 1'b0;
		end
		else
		begin
			state <= next_state;
			case (state)
				S_LOOKUP:
				begin
					dram_cs <= !res.hit;
					dram_we <= victim_wb;
				end
				// Write-back done, the fill follows back to back.
				S_WB:
					if (dram_ack)
						dram_we <= 1'b0;
				S_FILL:
					if (dram_ack)
						dram_cs <= 1'b0;
				default:
				begin
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		case (state)
			S_IDLE:
				if (cs)
					req <= '{we: we, addr: addr, wdata: wdata};
			S_LOOKUP:
			begin
				used_way <= res.hit ? res.hit_way[NUM_WAYS-1:0] : res.victim_way[NUM_WAYS-1:0];
				if (res.hit)
					line_data <= res.rdata;
				dram_addr <= victim_wb ? {res.victim_tag, lookup_index} : req.addr;
				dram_wdata <= res.victim_data;
			end
			S_WB:
				if (dram_ack)
					dram_addr <= req.addr;
			S_FILL:
				if (dram_ack)
					line_data <= dram_rdata;
			default:
			begin
			end
		endcase
	end

	// Writes store CPU data dirty, read fills store DRAM data clean.
	always_comb
	begin
		wr.index = lookup_index;
		wr.tag = lookup_tag;
		wr.data = req.we ? req.wdata : line_data;
		wr.valid = 1'b1;
		wr.dirty = req.we;
	end

	assign wr_sel = (state == S_UPDATE) ? used_way : '0;

	assign ack = (state == S_DONE);
	assign rdata = line_data;
	assign touch = (state == S_DONE);
	assign touch_way = used_way;

	a_wr_sel_onehot: assert property (@(posedge clk) disable iff (!rst)
		$onehot0(wr_sel));

	a_dram_hold: assert property (@(posedge clk) disable iff (!rst)
		dram_cs && !dram_ack |=> dram_cs && $stable(dram_we) && $stable(dram_addr));

	a_ack_pulse: assert property (@(posedge clk) disable iff (!rst)
		ack |=> !ack);

endmodule

// ==== hw/l1_cache.sv ====
`timescale 1ns/10ps

module l1_cache
	import cache_cfg_pkg::*;
	import cache_bus_pkg::*;
#(
	parameter int NUM_WAYS = 2
)
(
	input logic clk,
	input logic rst,
	input logic cs,
	input logic we,
	input logic [ADDR_W-1:0] addr,
	input logic [DATA_W-1:0] wdata,
	output logic ack,
	output logic [DATA_W-1:0] rdata,
	input logic dram_ack,
	input logic [DATA_W-1:0] dram_rdata,
	output logic dram_cs,
	output logic dram_we,
	output logic [ADDR_W-1:0] dram_addr,
	output logic [DATA_W-1:0] dram_wdata
);

	lookup_res_t res;
	way_status_t status [NUM_WAYS];
	way_wr_t wr;
	logic [NUM_WAYS-1:0] wr_sel;
	logic [INDEX_W-1:0] lookup_index;
	logic [TAG_W-1:0] lookup_tag;
	logic touch;
	logic [NUM_WAYS-1:0] touch_way;

	cache_controller #(
		.NUM_WAYS(NUM_WAYS)
	) u_ctrl (
		.clk(clk),
		.rst(rst),
		.cs(cs),
		.we(we),
		.addr(addr),
		.wdata(wdata),
		.ack(ack),
		.rdata(rdata),
		.res(res),
		.lookup_index(lookup_index),
		.lookup_tag(lookup_tag),
		.wr(wr),
		.wr_sel(wr_sel),
		.touch(touch),
		.touch_way(touch_way),
		.dram_ack(dram_ack),
		.dram_rdata(dram_rdata),
		.dram_cs(dram_cs),
		.dram_we(dram_we),
		.dram_addr(dram_addr),
		.dram_wdata(dram_wdata)
	);

	for (genvar i = 0; i < NUM_WAYS; i++)
	begin : g_way
		cache_way u_way (
			.clk(clk),
			.rst(rst),
			.lookup_index(lookup_index),
			.lookup_tag(lookup_tag),
			.wr(wr),
			.sel(wr_sel[i]),
			.status(status[i])
		);
	end

	way_select #(
		.NUM_WAYS(NUM_WAYS)
	) u_sel (
		.clk(clk),
		.rst(rst),
		.status(status),
		.lookup_index(lookup_index),
		.touch(touch),
		.touch_way(touch_way),
		.res(res)
	);

endmodule

// ==== test/dram_model.sv ====
`timescale 1ns/10ps

module dram_model
	import cache_cfg_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic dram_cs,
	input logic dram_we,
	input logic [ADDR_W-1:0] dram_addr,
	input logic [DATA_W-1:0] dram_wdata,
	output logic dram_ack,
	output logic [DATA_W-1:0] dram_rdata
);

	logic [DATA_W-1:0] mem [1 << ADDR_W];
	logic busy;
	logic [1:0] wait_cnt;
	integer seed;

	// Power-up contents: the address in the upper half, its complement below.
	function automatic logic [DATA_W-1:0] init_word(input logic [ADDR_W-1:0] a);
		return {a, ~a};
	endfunction

	// Backdoor read, no bus cycle.
	function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] a);
		return mem[a];
	endfunction

	initial
	begin
		seed = 32'h1d00;
		for (int i = 0; i < (1 << ADDR_W); i++)
			mem[i] = init_word(ADDR_W'(i));
	end

	always @(posedge clk)
	begin
		if (!rst)
		begin
			dram_ack <= 1'b0;
			busy <= 1'b0;
			wait_cnt <= 2'd0;
		end
		else
		begin
			dram_ack <= 1'b0;
			if (busy)
			begin
				if (wait_cnt == 2'd0)
				begin
					busy <= 1'b0;
					dram_ack <= 1'b1;
					if (dram_we)
						mem[dram_addr] = dram_wdata;
					else
						dram_rdata <= mem[dram_addr];
				end
				else
					wait_cnt <= wait_cnt - 2'd1;
			end
			// A new request only once the last ack has been seen by the controller.
			else if (dram_cs && !dram_ack)
			begin
				busy <= 1'b1;
				wait_cnt <= 2'($unsigned($random(seed)) % 4);
			end
		end
	end

endmodule

// ==== test/tb_l1_cache.sv ====
`timescale 1ns/10ps

module tb_l1_cache
	import cache_cfg_pkg::*;
();

	localparam int MAX_OPS = 64;
	localparam int CYCLES_PER_OP = 20;

	// Operation codes in the stimulus file.
	localparam logic [3:0] OP_READ = 4'd1;
	localparam logic [3:0] OP_WRITE = 4'd2;
	localparam logic [3:0] OP_CHECK = 4'd3;
	localparam logic [3:0] OP_HIT_READ = 4'd4;

	logic clk;
	logic rst;
	logic cs;
	logic we;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic ack;
	logic [DATA_W-1:0] rdata;
	logic dram_cs;
	logic dram_we;
	logic [ADDR_W-1:0] dram_addr;
	logic [DATA_W-1:0] dram_wdata;
	logic dram_ack;
	logic [DATA_W-1:0] dram_rdata;

	// Op, address, write data, expected data.
	logic [83:0] ops [MAX_OPS];
	int num_ops;
	int cycle_count = 0;
	int cycle_limit = 0;

	l1_cache #(
		.NUM_WAYS(2)
	) dut (
		.clk(clk),
		.rst(rst),
		.cs(cs),
		.we(we),
		.addr(addr),
		.wdata(wdata),
		.ack(ack),
		.rdata(rdata),
		.dram_ack(dram_ack),
		.dram_rdata(dram_rdata),
		.dram_cs(dram_cs),
		.dram_we(dram_we),
		.dram_addr(dram_addr),
		.dram_wdata(dram_wdata)
	);

	dram_model u_dram (
		.clk(clk),
		.rst(rst),
		.dram_cs(dram_cs),
		.dram_we(dram_we),
		.dram_addr(dram_addr),
		.dram_wdata(dram_wdata),
		.dram_ack(dram_ack),
		.dram_rdata(dram_rdata)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
			$display("STATUS: FAIL");
			$fatal(1, "Simulation timed out");
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// One CPU access from cs to ack, counting the edge at which ack is sampled.
	task automatic run_access(input logic write, input logic [ADDR_W-1:0] a,
		input logic [DATA_W-1:0] d, output logic [DATA_W-1:0] data_out,
		output int edges, output logic dram_used);
		@(negedge clk);
		cs = 1'b1;
		we = write;
		addr = a;
		wdata = d;
		edges = 0;
		dram_used = 1'b0;
		do
		begin
			@(negedge clk);
			edges++;
			if (dram_cs)
				dram_used = 1'b1;
		end while (!ack);
		data_out = rdata;
		cs = 1'b0;
		we = 1'b0;
	endtask

	initial
	begin
		logic [3:0] op;
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] d;
		logic [DATA_W-1:0] expected;
		logic [DATA_W-1:0] got;
		int edges;
		logic dram_used;

		rst = 1'b0;
		cs = 1'b0;
		we = 1'b0;
		addr = '0;
		wdata = '0;
		for (int i = 0; i < MAX_OPS; i++)
			ops[i] = '0;
		$readmemh("test/cache_input.txt", ops);
		num_ops = 0;
		while (num_ops < MAX_OPS && ops[num_ops][83:80] != 4'd0)
			num_ops++;
		if (num_ops == 0)
		begin
			$display("No operations could be read from test/cache_input.txt.");
			$display("STATUS: FAIL");
			$fatal(1, "Empty stimulus");
		end
		cycle_limit = (num_ops + 1) * CYCLES_PER_OP;

		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		check_value("ack", 32'(ack), 32'd0);
		check_value("dram_cs", 32'(dram_cs), 32'd0);
		check_value("dram_we", 32'(dram_we), 32'd0);

		for (int n = 0; n < num_ops; n++)
		begin
			op = ops[n][83:80];
			a = ops[n][79:64];
			d = ops[n][63:32];
			expected = ops[n][31:0];
			case (op)
				OP_READ, OP_HIT_READ:
				begin
					run_access(1'b0, a, '0, got, edges, dram_used);
					check_value($sformatf("rdata @%h", a), got, expected);
					// A hit is acked at edge 2 and never touches DRAM.
					if (op == OP_HIT_READ)
					begin
						check_value("ack edge", 32'(edges), 32'd2);
						check_value("dram_cs", 32'(dram_used), 32'd0);
					end
				end
				OP_WRITE:
					run_access(1'b1, a, d, got, edges, dram_used);
				OP_CHECK:
					check_value($sformatf("dram word @%h", a), u_dram.read_word(a), expected);
				default:
				begin
					$display("Unknown operation code %0h on stimulus entry %0d.", op, n);
					$display("STATUS: FAIL");
					$fatal(1, "Bad stimulus");
				end
			endcase
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== test/cache_input.txt ====
// Columns: op_addr_wdata_expected in hex. Op 1 read, 2 write, 3 DRAM backdoor check,
// 4 read that must hit (ack at edge 2, no DRAM cycle). DRAM starts as {addr, ~addr}.
1_0013_00000000_0013ffec
4_0013_00000000_0013ffec
2_0013_11112222_00000000
4_0013_00000000_11112222
3_0013_00000000_0013ffec
2_0025_aaaa5555_00000000
4_0025_00000000_aaaa5555
1_0123_00000000_0123fedc
1_0233_00000000_0233fdcc
3_0013_00000000_11112222
1_0013_00000000_11112222
4_0233_00000000_0233fdcc
2_0107_0badf00d_00000000
2_0217_12345678_00000000
1_0327_00000000_0327fcd8
3_0107_00000000_0badf00d
4_0217_00000000_12345678
1_0107_00000000_0badf00d
3_0217_00000000_0217fde8
4_0025_00000000_aaaa5555
2_0035_cafe0001_00000000
2_0045_cafe0002_00000000
3_0025_00000000_aaaa5555
4_0035_00000000_cafe0001
4_0045_00000000_cafe0002
1_0ff0_00000000_0ff0f00f
1_ffff_00000000_ffff0000
4_0ff0_00000000_0ff0f00f

// ==== files.f ====
hw/cache_cfg_pkg.sv
hw/cache_bus_pkg.sv
hw/cache_way.sv
hw/way_select.sv
hw/cache_controller.sv
hw/l1_cache.sv
test/dram_model.sv
test/tb_l1_cache.sv

// ==== Makefile ====
LOG = sim.log

all: run

run:
	verilator --binary --timing --assert -f files.f --top-module tb_l1_cache --Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	verilator --lint-only --timing -f files.f --top-module tb_l1_cache

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean
